/* filelist.f */
+incdir+.
rf_pkg.sv
rf_write_packer.sv
rf_read_sequencer.sv
rf_ram.sv
rf_serial_top.sv
rf_serial_checker.sv
tb_rf_serial.sv

/* rf_cases.txt */
# w reg0 reg1 en0 en1 data0 data1 | r reg0 reg1 exp0 exp1 (indices decimal, words hex)
# f fills all registers with random words, v reads all registers back in pairs
w 1 2 1 1 deadbeef 12345678
r 1 2 deadbeef 12345678
w 3 4 1 1 a5a5a5a5 5a5a5a5a
r 3 4 a5a5a5a5 5a5a5a5a
w 1 2 1 0 0f0f0f0f ffffffff
r 1 2 0f0f0f0f 12345678
w 3 4 0 1 00000000 80000001
r 3 4 a5a5a5a5 80000001
r 3 3 a5a5a5a5 a5a5a5a5
r 2 1 12345678 0f0f0f0f
w 32 33 1 1 c0de0001 c0de0002
w 34 35 1 1 c0de0003 c0de0004
r 32 35 c0de0001 c0de0004
r 34 33 c0de0003 c0de0002
w 7 7 1 1 11111111 22222222
r 7 7 22222222 22222222
w 0 31 1 1 00000000 ffffffff
r 31 0 ffffffff 00000000
f
v

/* rf_defs.svh */
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// 32 general registers plus 4 csr shadow slots
`define RF_NUM_REGS   36

// serial length of one register
`define RF_DATA_BITS  32

// width of one ram word
`define RF_WORD_BITS  2

// bit counter width for one register pass
`define RF_CNT_BITS   5

`define RF_SLOTS      (`RF_DATA_BITS / `RF_WORD_BITS)
`define RF_RAM_DEPTH  (`RF_NUM_REGS * `RF_SLOTS)

`endif

/* rf_pkg.sv */
`include "rf_defs.svh"

package rf_pkg;

   typedef logic [$clog2(`RF_NUM_REGS)-1:0]  reg_idx_t;   // register index
   typedef logic [$clog2(`RF_SLOTS)-1:0]     slot_t;      // word slot inside a register
   typedef logic [$clog2(`RF_RAM_DEPTH)-1:0] ram_addr_t;  // register index above slot
   typedef logic [`RF_WORD_BITS-1:0]         ram_word_t;  // bit 0 is the even serial bit

   // one ram write per clock from the packer
   typedef struct packed {
      logic      en;
      ram_addr_t addr;
      ram_word_t data;
   } ram_wr_t;

   // one ram read per clock from the sequencer
   typedef struct packed {
      ram_addr_t addr;
   } ram_rd_t;

endpackage

/* rf_ram.sv */
`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_ram (
   input  logic              i_clk,
   input  rf_pkg::ram_wr_t   i_wr,
   input  rf_pkg::ram_rd_t   i_rd,
   output rf_pkg::ram_word_t o_rword
);
   import rf_pkg::*;

   // 16 two-bit slots per register
   ram_word_t mem [0:`RF_RAM_DEPTH-1];

   always_ff @(posedge i_clk) begin
      if (i_wr.en)
         mem[i_wr.addr] <= i_wr.data;
   end

   // registered read with one cycle from address to word
   always_ff @(posedge i_clk) begin
      o_rword <= mem[i_rd.addr];
   end

endmodule

/* rf_read_sequencer.sv */
`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_read_sequencer (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic              i_rreq,
   input  rf_pkg::reg_idx_t  i_rreg0,
   input  rf_pkg::reg_idx_t  i_rreg1,
   input  rf_pkg::ram_word_t i_rword,
   output rf_pkg::ram_rd_t   o_rd,
   output logic              o_rgnt,
   output logic              o_rdata0,
   output logic              o_rdata1
);
   import rf_pkg::*;

   logic [`RF_CNT_BITS-1:0] rcnt;
   logic                    rreq_r;
   logic                    rport;     // 0 addresses port 0 and 1 addresses port 1
   slot_t                   rslot;
   reg_idx_t                rreg;

   ram_word_t               rword0_r;  // port 0 word held for two bit times
   logic                    rdata1_r;  // upper bit of the port 1 word

   assign rslot = rcnt[`RF_CNT_BITS-1:1];
   assign rport = rcnt[0];
   assign rreg  = rport ? i_rreg1 : i_rreg0;

   assign o_rd.addr = {rreg, rslot};

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         rcnt   <= '0;
         rreq_r <= 1'b0;
         o_rgnt <= 1'b0;
      end else begin
         if (i_rreq)
            rcnt <= '0;                // a new request restarts the read pass
         else
            rcnt <= rcnt + 1'b1;
         rreq_r <= i_rreq;
         o_rgnt <= rreq_r;
      end
   end

   // the ram answers one cycle after the address
   // so the port 0 word arrives while rport is high
   always_ff @(posedge i_clk) begin
      if (rport)
         rword0_r <= i_rword;
      if (!rport)
         rdata1_r <= i_rword[1];
   end

   // port 0 shows its held word lower bit first
   assign o_rdata0 = rport ? rword0_r[1] : rword0_r[0];

   // port 1 takes the lower bit straight from the ram
   assign o_rdata1 = rport ? rdata1_r : i_rword[0];

endmodule

/* rf_serial_checker.sv */
`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_serial_checker (
   input logic            i_clk,
   input logic            i_rst,
   input logic            i_wreq,
   input logic            i_rreq,
   input logic            i_rgnt,
   input rf_pkg::ram_wr_t i_wr
);
   import rf_pkg::*;

   logic [5:0] wage;   // cycles since the last write request, saturates at all ones

   always_ff @(posedge i_clk) begin
      if (i_rst)
         wage <= '1;
      else if (i_wreq)
         wage <= '0;
      else if (wage != '1)
         wage <= wage + 1'b1;
   end

   // the grant is the read strobe delayed by two clocks
   a_gnt_delay: assert property (@(posedge i_clk) disable iff (i_rst)
      i_rgnt == $past(i_rreq, 2))
      else $error("grant does not follow the read request by two cycles");

   a_gnt_reset: assert property (@(posedge i_clk) i_rst |=> !i_rgnt)
      else $error("grant is high during reset");

   // words land from two to thirty-three cycles after the strobe
   a_wr_window: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wr.en |-> (wage >= 6'd1 && wage <= 6'(`RF_DATA_BITS)))
      else $error("ram write enable outside the write window");

endmodule

/* rf_serial_top.sv */
`timescale 1ns/100ps

module rf_serial_top (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_wreq,
   input  logic             i_rreq,
   output logic             o_rgnt,
   input  rf_pkg::reg_idx_t i_wreg0,
   input  rf_pkg::reg_idx_t i_wreg1,
   input  logic             i_wen0,
   input  logic             i_wen1,
   input  logic             i_wdata0,
   input  logic             i_wdata1,
   input  rf_pkg::reg_idx_t i_rreg0,
   input  rf_pkg::reg_idx_t i_rreg1,
   output logic             o_rdata0,
   output logic             o_rdata1
);
   import rf_pkg::*;

   ram_wr_t   ram_wr;    // packer to ram
   ram_rd_t   ram_rd;    // sequencer to ram
   ram_word_t ram_word;  // ram back to sequencer

   rf_write_packer u_packer (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wreq   (i_wreq),
      .i_wreg0  (i_wreg0),
      .i_wreg1  (i_wreg1),
      .i_wen0   (i_wen0),
      .i_wen1   (i_wen1),
      .i_wdata0 (i_wdata0),
      .i_wdata1 (i_wdata1),
      .o_wr     (ram_wr)
   );

   rf_read_sequencer u_sequencer (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rreq   (i_rreq),
      .i_rreg0  (i_rreg0),
      .i_rreg1  (i_rreg1),
      .i_rword  (ram_word),
      .o_rd     (ram_rd),
      .o_rgnt   (o_rgnt),
      .o_rdata0 (o_rdata0),
      .o_rdata1 (o_rdata1)
   );

   rf_ram u_ram (
      .i_clk    (i_clk),
      .i_wr     (ram_wr),
      .i_rd     (ram_rd),
      .o_rword  (ram_word)
   );

endmodule

/* rf_write_packer.sv */
`timescale 1ns/100ps
`include "rf_defs.svh"

module rf_write_packer (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_wreq,
   input  rf_pkg::reg_idx_t i_wreg0,
   input  rf_pkg::reg_idx_t i_wreg1,
   input  logic             i_wen0,
   input  logic             i_wen1,
   input  logic             i_wdata0,
   input  logic             i_wdata1,
   output rf_pkg::ram_wr_t  o_wr
);
   import rf_pkg::*;

   logic [`RF_CNT_BITS-1:0] wcnt;
   logic                    wgo;       // write window open
   logic                    wreq_r;
   logic                    wlast;
   logic                    wport;     // 0 selects port 0 and 1 selects port 1
   slot_t                   wslot;
   reg_idx_t                wreg;

   logic                    wen0_r;
   logic                    wen1_r;
   logic                    wdata0_r;
   logic                    wdata1_r;
   logic                    wdata1_2r; // port 1 lags a further cycle behind port 0

   assign wslot = wcnt[`RF_CNT_BITS-1:1];
   assign wport = wcnt[0];
   assign wlast = &wcnt;               // count 31 ends the window
   assign wreg  = wport ? i_wreg1 : i_wreg0;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         wreq_r <= 1'b0;
         wgo    <= 1'b0;
         wcnt   <= '0;
      end else begin
         wreq_r <= i_wreq;
         if (wgo)
            wcnt <= wcnt + 1'b1;       // wraps back to zero after the last word
         if (wgo && wlast)
            wgo <= 1'b0;
         else if (wreq_r)
            wgo <= 1'b1;
      end
   end

   // serial delay lines for data and enables
   always_ff @(posedge i_clk) begin
      wen0_r    <= i_wen0;
      wen1_r    <= i_wen1;
      wdata0_r  <= i_wdata0;
      wdata1_r  <= i_wdata1;
      wdata1_2r <= wdata1_r;
   end

   // even counts carry port 0 and odd counts carry port 1
   always_comb begin
      o_wr.en   = wgo & (wport ? wen1_r : wen0_r);
      o_wr.addr = {wreg, wslot};
      if (wport)
         o_wr.data = {wdata1_r, wdata1_2r};
      else
         o_wr.data = {i_wdata0, wdata0_r};
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps -f filelist.f \
   --top-module tb_rf_serial -o sim_rf_serial
./obj_dir/sim_rf_serial | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

/* tb_rf_serial.sv */
`timescale 1ns/100ps
`include "rf_defs.svh"

module tb_rf_serial;
   import rf_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int GNT_LIMIT   = 8;    // cycles to wait for a grant
   localparam int CASE_CYCLES = 40;   // upper bound for one register pair pass

   typedef logic [`RF_DATA_BITS-1:0] reg_word_t;

   // one write or one read of a register pair
   typedef struct packed {
      logic      is_write;
      logic      file_exp;   // read words were given in the cases file
      reg_idx_t  reg0;
      reg_idx_t  reg1;
      logic      en0;
      logic      en1;
      reg_word_t data0;
      reg_word_t data1;
   } case_t;

   logic     i_clk = 1'b0;
   logic     i_rst;
   logic     i_wreq;
   logic     i_rreq;
   logic     o_rgnt;
   reg_idx_t i_wreg0;
   reg_idx_t i_wreg1;
   logic     i_wen0;
   logic     i_wen1;
   logic     i_wdata0;
   logic     i_wdata1;
   reg_idx_t i_rreg0;
   reg_idx_t i_rreg1;
   logic     o_rdata0;
   logic     o_rdata1;

   case_t     cases[$];
   reg_word_t model [0:`RF_NUM_REGS-1];
   logic      written [0:`RF_NUM_REGS-1];
   int        pass_count;
   int        fail_count;
   logic      loaded;

   rf_serial_top uut (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_wreq   (i_wreq),
      .i_rreq   (i_rreq),
      .o_rgnt   (o_rgnt),
      .i_wreg0  (i_wreg0),
      .i_wreg1  (i_wreg1),
      .i_wen0   (i_wen0),
      .i_wen1   (i_wen1),
      .i_wdata0 (i_wdata0),
      .i_wdata1 (i_wdata1),
      .i_rreg0  (i_rreg0),
      .i_rreg1  (i_rreg1),
      .o_rdata0 (o_rdata0),
      .o_rdata1 (o_rdata1)
   );

   bind rf_serial_top rf_serial_checker u_checker (
      .i_clk  (i_clk),
      .i_rst  (i_rst),
      .i_wreq (i_wreq),
      .i_rreq (i_rreq),
      .i_rgnt (o_rgnt),
      .i_wr   (ram_wr)
   );

   always #(CLK_PERIOD/2) i_clk = ~i_clk;

   task automatic add_case(input logic wr, input logic fexp, input int r0, input int r1,
                           input logic e0, input logic e1, input reg_word_t d0,
                           input reg_word_t d1);
      case_t c;
      if (r0 < 0 || r0 >= `RF_NUM_REGS || r1 < 0 || r1 >= `RF_NUM_REGS) begin
         $display("cases file names a register outside 0 to %0d", `RF_NUM_REGS - 1);
         fail_count++;
      end else begin
         c.is_write = wr;
         c.file_exp = fexp;
         c.reg0     = reg_idx_t'(r0);
         c.reg1     = reg_idx_t'(r1);
         c.en0      = e0;
         c.en1      = e1;
         c.data0    = d0;
         c.data1    = d1;
         cases.push_back(c);
      end
   endtask

   // f writes every register with random words, v reads them all back in pairs
   task automatic load_cases();
      int               fd;
      int               code;
      int               r0;
      int               r1;
      int               e0;
      int               e1;
      logic [7:0]       op;
      logic [8*128-1:0] rest;
      reg_word_t        d0;
      reg_word_t        d1;
      fd = $fopen("rf_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open rf_cases.txt");
         fail_count++;
         return;
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", op);
         if (code != 1)
            break;
         if (op == "#") begin
            code = $fgets(rest, fd);
         end else if (op == "w") begin
            code = $fscanf(fd, "%d %d %d %d %h %h", r0, r1, e0, e1, d0, d1);
            if (code != 6) begin
               $display("malformed write line in rf_cases.txt");
               fail_count++;
            end else
               add_case(1'b1, 1'b0, r0, r1, e0 != 0, e1 != 0, d0, d1);
         end else if (op == "r") begin
            code = $fscanf(fd, "%d %d %h %h", r0, r1, d0, d1);
            if (code != 4) begin
               $display("malformed read line in rf_cases.txt");
               fail_count++;
            end else
               add_case(1'b0, 1'b1, r0, r1, 1'b0, 1'b0, d0, d1);
         end else if (op == "f") begin
            for (int i = 0; i < `RF_NUM_REGS; i += 2)
               add_case(1'b1, 1'b0, i, i + 1, 1'b1, 1'b1, $urandom(), $urandom());
         end else if (op == "v") begin
            for (int i = 0; i < `RF_NUM_REGS; i += 2)
               add_case(1'b0, 1'b0, i, i + 1, 1'b0, 1'b0, '0, '0);
         end else begin
            $display("unknown operation in rf_cases.txt");
            fail_count++;
         end
      end
      $fclose(fd);
   endtask

   // bit k goes out in cycle c+1+k after the strobe in cycle c
   task automatic run_write(input int num, input case_t c);
      @(posedge i_clk);
      #1;
      i_wreq  = 1'b1;
      i_wreg0 = c.reg0;
      i_wreg1 = c.reg1;
      i_wen0  = c.en0;
      i_wen1  = c.en1;
      @(posedge i_clk);
      #1;
      i_wreq = 1'b0;
      for (int k = 0; k < `RF_DATA_BITS; k++) begin
         i_wdata0 = c.data0[k];
         i_wdata1 = c.data1[k];
         @(posedge i_clk);
         #1;
      end
      @(posedge i_clk);   // last word lands at the end of cycle c+33
      #1;
      i_wen0 = 1'b0;
      i_wen1 = 1'b0;
      if (c.en0) begin
         model[c.reg0]   = c.data0;
         written[c.reg0] = 1'b1;
      end
      if (c.en1) begin   // port 1 writes each slot after port 0
         model[c.reg1]   = c.data1;
         written[c.reg1] = 1'b1;
      end
      $display("case %0d write x%0d x%0d done", num, c.reg0, c.reg1);
   endtask

   task automatic run_read(input int num, input case_t c, output int errs);
      int        waited;
      reg_word_t exp0;
      reg_word_t exp1;
      reg_word_t got0;
      reg_word_t got1;
      errs = 0;
      got0 = '0;
      got1 = '0;
      exp0 = model[c.reg0];
      exp1 = model[c.reg1];
      if (!written[c.reg0] || !written[c.reg1]) begin
         $display("case %0d reads a register that was never written", num);
         errs++;
      end
      if (c.file_exp && (c.data0 !== exp0 || c.data1 !== exp1)) begin
         $display("case %0d expects %h %h in the cases file but the model holds %h %h",
                  num, c.data0, c.data1, exp0, exp1);
         errs++;
      end
      @(posedge i_clk);
      #1;
      i_rreq  = 1'b1;
      i_rreg0 = c.reg0;
      i_rreg1 = c.reg1;
      @(posedge i_clk);
      #1;
      i_rreq = 1'b0;
      waited = 0;
      do begin
         @(negedge i_clk);
         waited++;
      end while (!o_rgnt && waited < GNT_LIMIT);
      if (!o_rgnt) begin
         $display("case %0d got no grant within %0d cycles of the read request",
                  num, GNT_LIMIT);
         errs++;
      end else begin
         if (waited != 2) begin
            $display("case %0d got its grant %0d cycles after the request instead of 2",
                     num, waited);
            errs++;
         end
         for (int k = 0; k < `RF_DATA_BITS; k++) begin
            @(negedge i_clk);
            if (k == 0 && o_rgnt) begin
               $display("case %0d grant stayed high for more than one cycle", num);
               errs++;
            end
            got0[k] = o_rdata0;
            got1[k] = o_rdata1;
         end
         if (got0 !== exp0) begin
            $display("Fail o_rdata0 (case %0d, x%0d): expected 0x%h, got 0x%h",
                     num, c.reg0, exp0, got0);
            errs++;
         end
         if (got1 !== exp1) begin
            $display("Fail o_rdata1 (case %0d, x%0d): expected 0x%h, got 0x%h",
                     num, c.reg1, exp1, got1);
            errs++;
         end
      end
      $display("case %0d read x%0d x%0d %s", num, c.reg0, c.reg1,
               (errs == 0) ? "ok" : "failed");
   endtask

   initial begin
      int errs;
      void'($urandom(38));
      loaded     = 1'b0;
      pass_count = 0;
      fail_count = 0;
      i_rst      = 1'b1;
      i_wreq     = 1'b0;
      i_rreq     = 1'b0;
      i_wreg0    = '0;
      i_wreg1    = '0;
      i_wen0     = 1'b0;
      i_wen1     = 1'b0;
      i_wdata0   = 1'b0;
      i_wdata1   = 1'b0;
      i_rreg0    = '0;
      i_rreg1    = '0;
      for (int i = 0; i < `RF_NUM_REGS; i++)
         written[i] = 1'b0;
      load_cases();
      loaded = 1'b1;
      repeat (8) @(posedge i_clk);
      #1;
      i_rst = 1'b0;
      foreach (cases[i]) begin
         if (cases[i].is_write) begin
            run_write(i, cases[i]);
            pass_count++;
         end else begin
            run_read(i, cases[i], errs);
            if (errs == 0)
               pass_count++;
            else
               fail_count++;
         end
      end
      $display("%0d cases passed, %0d cases failed", pass_count, fail_count);
      if (fail_count == 0 && pass_count > 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog sized from the number of register pair passes
   initial begin
      int limit;
      wait (loaded);
      limit = cases.size() * CASE_CYCLES + 100;
      repeat (limit) @(posedge i_clk);
      $display("timeout, the run did not finish within %0d clock periods", limit);
      $display("*** FAILED ***");
      $finish;
   end

endmodule
